//--- design/branch_cfg.svh
// Widths and queue depth for the branch execution slice
// BR_B_IMM counts the immediate bits before the implicit low zero
`ifndef BRANCH_CFG_SVH
`define BRANCH_CFG_SVH

// Data and address width of the core
`define BR_XLEN 32

// B-type immediate width as held in the op
// Signed value, doubled when forming the target
`define BR_B_IMM 12

// Default number of entries in the branch issue queue
// Any value of 1 or more is accepted
`define BR_QUEUE_DEPTH 2

// Fixed distance to the fall-through instruction
// Only uncompressed instructions are handled
`define BR_INSTR_BYTES 4

`endif

//--- design/branch_pkg.sv
// Types shared by the branch execution slice
// Field widths follow branch_cfg.svh
`include "branch_cfg.svh"

package branch_pkg;

    // Branch condition, coded like the RV32 funct3 field
    // Codes 3'b010 and 3'b011 are unused and never take the branch
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } bu_ctl_e;

    // Decoded conditional branch as it leaves dispatch
    // Operands are already read, so the op can issue at once
    typedef struct packed {
        // Comparison to perform
        bu_ctl_e                 ctl;
        // First source operand
        logic [`BR_XLEN-1:0]     rs1;
        // Second source operand
        logic [`BR_XLEN-1:0]     rs2;
        // Address of the branch itself
        logic [`BR_XLEN-1:0]     pc;
        // Target the front end fetched from when predicted taken
        logic [`BR_XLEN-1:0]     pred_target;
        // B-immediate without its low zero bit
        logic [`BR_B_IMM-1:0]    imm;
        // Direction chosen by the front end
        logic                    pred_taken;
    } branch_op_t;

    // Resolved branch
    typedef struct packed {
        // Address of the resolved branch
        logic [`BR_XLEN-1:0]     pc;
        // Computed target, valid whether or not taken
        logic [`BR_XLEN-1:0]     target;
        // Real direction
        logic                    taken;
        // Wrong direction, or wrong target on a taken branch
        logic                    mispredict;
    } branch_res_t;

endpackage

//--- design/branch_issue_queue.sv
// In-order queue of ready branch ops, push and pop may coincide even when full
// Flush drops every entry and blocks pushes in that cycle
`timescale 1ns/10ps
`include "branch_cfg.svh"

module branch_issue_queue #(
    parameter int DEPTH = `BR_QUEUE_DEPTH
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    push_valid_i,
    input  branch_pkg::branch_op_t  push_op_i,
    input  logic                    pop_ready_i,
    input  logic                    flush_i,
    output logic                    push_ready_o,
    output logic                    pop_valid_o,
    output branch_pkg::branch_op_t  pop_op_o
);
    import branch_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Entry storage
    branch_op_t         mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               full;
    logic               empty;
    logic               push_fire;
    logic               pop_fire;

    // Pointer step with wrap, DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // A pop in the same cycle frees the slot the push needs
    assign push_ready_o = !flush_i && (!full || pop_ready_i);
    assign pop_valid_o  = !empty;
    assign pop_op_o     = mem[rd_ptr];

    assign push_fire = push_valid_i && push_ready_o;
    assign pop_fire  = pop_valid_o && pop_ready_i;

    // Payload write
    always_ff @(posedge clk_i) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_op_i;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            // Everything queued is younger than the redirecting branch
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_fire) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push_fire, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // A push into a full queue never overruns the occupancy count
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        count <= CNT_W'(DEPTH));

    // An empty queue keeps its pointers together
    // A pop from an empty queue would leave them apart
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        empty |-> (wr_ptr == rd_ptr));

endmodule

//--- design/branch_unit_cu.sv
// Accept and result-valid sequencing for the branch unit, one op per cycle
// Results have no back-pressure, a flush squashes the result of the same cycle
`timescale 1ns/10ps

module branch_unit_cu (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    ops_valid_i,
    input  logic    flush_i,
    input  logic    taken_i,
    input  logic    mispredict_i,
    output logic    ops_ready_o,
    output logic    accept_o,
    output logic    res_valid_o,
    output logic    res_taken_o,
    output logic    res_mispredict_o
);

    // Goes high on the first edge after reset release
    logic ready_en_q;
    // Result register holds an op
    logic valid_q;
    // Flags of the held op
    logic taken_q;
    logic mispredict_q;

    // Nothing is taken during a flush, the op at the queue head is dropped there
    assign ops_ready_o = ready_en_q && !flush_i;
    assign accept_o    = ops_valid_i && ops_ready_o;

    // Op accepted in the cycle of the mispredict is younger
    assign res_valid_o      = valid_q && !flush_i;
    assign res_taken_o      = taken_q;
    assign res_mispredict_o = mispredict_q;

    // Control state
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ready_en_q <= 1'b0;
            valid_q    <= 1'b0;
        end else begin
            ready_en_q <= 1'b1;
            // Flush forces accept_o low so the squashed op leaves here
            valid_q    <= accept_o;
        end
    end

    // Flags follow the op into the result register
    always_ff @(posedge clk_i) begin
        if (accept_o) begin
            taken_q      <= taken_i;
            mispredict_q <= mispredict_i;
        end
    end

    // Every visible result carries known flags for the redirect stage
    a_res_flags_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res_valid_o |-> !$isunknown({res_taken_o, res_mispredict_o}));

endmodule

//--- design/branch_unit.sv
// Resolves one conditional branch per cycle, result shows one cycle after accept
// Target alignment is not checked
`timescale 1ns/10ps
`include "branch_cfg.svh"

module branch_unit (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    ops_valid_i,
    input  branch_pkg::branch_op_t  op_i,
    input  logic                    flush_i,
    output logic                    ops_ready_o,
    output logic                    res_valid_o,
    output branch_pkg::branch_res_t res_o
);
    import branch_pkg::*;

    // Condition outcome
    logic                   taken;
    // Prediction checks
    logic                   wrong_dir;
    logic                   wrong_target;
    logic                   mispredict;
    // Sign-extended, doubled immediate
    logic [`BR_XLEN-1:0]    imm_ext;
    logic [`BR_XLEN-1:0]    target;
    logic                   accept;
    // Result payload
    logic [`BR_XLEN-1:0]    pc_q;
    logic [`BR_XLEN-1:0]    target_q;
    logic                   res_taken;
    logic                   res_mispredict;

    // Compare by condition code
    always_comb begin
        case (op_i.ctl)
            BEQ:     taken = (op_i.rs1 == op_i.rs2);
            BNE:     taken = (op_i.rs1 != op_i.rs2);
            BLT:     taken = ($signed(op_i.rs1) < $signed(op_i.rs2));
            BGE:     taken = ($signed(op_i.rs1) >= $signed(op_i.rs2));
            BLTU:    taken = (op_i.rs1 < op_i.rs2);
            BGEU:    taken = (op_i.rs1 >= op_i.rs2);
            // Unused codes fall through
            default: taken = 1'b0;
        endcase
    end

    // Target relative to the branch address
    assign imm_ext = {{(`BR_XLEN - `BR_B_IMM - 1){op_i.imm[`BR_B_IMM-1]}}, op_i.imm, 1'b0};
    assign target  = op_i.pc + imm_ext;

    // Target only matters when the branch really goes there
    assign wrong_dir    = (op_i.pred_taken != taken);
    assign wrong_target = taken && (op_i.pred_target != target);
    assign mispredict   = wrong_dir || wrong_target;

    branch_unit_cu u_branch_unit_cu (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .ops_valid_i      (ops_valid_i),
        .flush_i          (flush_i),
        .taken_i          (taken),
        .mispredict_i     (mispredict),
        .ops_ready_o      (ops_ready_o),
        .accept_o         (accept),
        .res_valid_o      (res_valid_o),
        .res_taken_o      (res_taken),
        .res_mispredict_o (res_mispredict)
    );

    // Address payload, loaded with the flags held in the control unit
    always_ff @(posedge clk_i) begin
        if (accept) begin
            pc_q     <= op_i.pc;
            target_q <= target;
        end
    end

    always_comb begin
        res_o            = '0;
        res_o.pc         = pc_q;
        res_o.target     = target_q;
        res_o.taken      = res_taken;
        res_o.mispredict = res_mispredict;
    end

endmodule

//--- design/branch_redirect.sv
// Turns a mispredicted result into a one-cycle fetch redirect
// The redirect pulse is also the flush of all younger branch work
`timescale 1ns/10ps
`include "branch_cfg.svh"

module branch_redirect (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    res_valid_i,
    input  branch_pkg::branch_res_t res_i,
    output logic                    redirect_valid_o,
    output logic [`BR_XLEN-1:0]     redirect_pc_o
);

    // Mispredicted result this cycle
    logic                   fire;
    // Fall-through address
    logic [`BR_XLEN-1:0]    seq_pc;
    // Address fetch must restart from
    logic [`BR_XLEN-1:0]    fix_pc;
    logic                   valid_q;
    logic [`BR_XLEN-1:0]    pc_q;

    assign fire   = res_valid_i && res_i.mispredict;
    assign seq_pc = res_i.pc + `BR_XLEN'(`BR_INSTR_BYTES);

    // Taken goes to the computed target, not taken falls through
    assign fix_pc = res_i.taken ? res_i.target : seq_pc;

    // Pulse drops by itself, results in the pulse cycle are squashed upstream
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fire;
        end
    end

    // Held address, only meaningful with the pulse
    always_ff @(posedge clk_i) begin
        if (fire) begin
            pc_q <= fix_pc;
        end
    end

    assign redirect_valid_o = valid_q;
    assign redirect_pc_o    = pc_q;

    // The flush must squash any result behind the branch, else a second pulse follows
    a_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        redirect_valid_o |=> !redirect_valid_o);

endmodule

//--- design/branch_exec.sv
// Branch execution slice: issue queue, branch unit and redirect stage
// Issue to result is 2 cycles and issue to redirect is 3 with an empty queue
`timescale 1ns/10ps
`include "branch_cfg.svh"

module branch_exec (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    issue_valid_i,
    input  branch_pkg::branch_op_t  issue_op_i,
    output logic                    issue_ready_o,
    output logic                    res_valid_o,
    output branch_pkg::branch_res_t res_o,
    output logic                    redirect_valid_o,
    output logic [`BR_XLEN-1:0]     redirect_pc_o
);
    import branch_pkg::*;

    // Queue head toward the branch unit
    logic       q_valid;
    branch_op_t q_op;
    logic       q_ready;
    // Redirect pulse fed back as flush
    logic       flush;

    assign flush = redirect_valid_o;

    branch_issue_queue #(
        .DEPTH (`BR_QUEUE_DEPTH)
    ) u_issue_queue (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .push_valid_i (issue_valid_i),
        .push_op_i    (issue_op_i),
        .pop_ready_i  (q_ready),
        .flush_i      (flush),
        .push_ready_o (issue_ready_o),
        .pop_valid_o  (q_valid),
        .pop_op_o     (q_op)
    );

    branch_unit u_branch_unit (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .ops_valid_i (q_valid),
        .op_i        (q_op),
        .flush_i     (flush),
        .ops_ready_o (q_ready),
        .res_valid_o (res_valid_o),
        .res_o       (res_o)
    );

    // Sees results after the flush squash, so wrong-path ops never redirect
    branch_redirect u_redirect (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .res_valid_i      (res_valid_o),
        .res_i            (res_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o)
    );

endmodule

//--- bench/tb_branch_exec.sv
// Directed testbench for the branch slice, assumes BR_XLEN of 32
// Results and redirects are collected mid-cycle and compared in order
`timescale 1ns/10ps
`include "branch_cfg.svh"

module tb_branch_exec;
    import branch_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYC  = 16;
    localparam int N_TESTS    = 5;
    // Worst test is well under this many cycles
    localparam int TEST_BOUND = 300;
    localparam int WAIT_LIMIT = 60;
    localparam int SETTLE_CYC = 6;

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   issue_valid_i;
    branch_op_t             issue_op_i;
    logic                   issue_ready_o;
    logic                   res_valid_o;
    branch_res_t            res_o;
    logic                   redirect_valid_o;
    logic [`BR_XLEN-1:0]    redirect_pc_o;

    // Observed and expected streams
    branch_res_t            got_res[$];
    branch_res_t            exp_res[$];
    logic [`BR_XLEN-1:0]    got_redir[$];
    logic [`BR_XLEN-1:0]    exp_redir[$];
    // issue_ready_o seen in each redirect cycle
    logic                   ready_in_flush[$];

    logic [31:0]            lfsr_q = 32'hd3f250c2;
    string                  test_name;
    int                     error_count = 0;
    int                     failed_tests = 0;
    int                     test_err_start;
    int                     stall_count;

    branch_exec uut (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .issue_valid_i    (issue_valid_i),
        .issue_op_i       (issue_op_i),
        .issue_ready_o    (issue_ready_o),
        .res_valid_o      (res_valid_o),
        .res_o            (res_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Outputs only move at the rising edge, so mid-cycle is stable
    always @(negedge clk_i) begin
        if (res_valid_o) begin
            got_res.push_back(res_o);
        end
        if (redirect_valid_o) begin
            got_redir.push_back(redirect_pc_o);
            ready_in_flush.push_back(issue_ready_o);
        end
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYC + N_TESTS * TEST_BOUND));
        $display("Watchdog expired, the tests did not complete in time");
        $display("Finished with errors");
        $finish;
    end

    // Fibonacci LFSR x^32+x^22+x^2+x+1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int nbits);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    // Reference resolution of one branch
    function automatic branch_res_t model_res(input branch_op_t op);
        branch_res_t r;
        int          offset;
        logic        eq;
        logic        lt_s;
        logic        lt_u;
        r    = '0;
        eq   = (op.rs1 == op.rs2);
        lt_u = (op.rs1 < op.rs2);
        // Flipping the sign bits maps signed order onto unsigned order
        lt_s = ((op.rs1 ^ 32'h8000_0000) < (op.rs2 ^ 32'h8000_0000));
        case (op.ctl)
            BEQ:     r.taken = eq;
            BNE:     r.taken = !eq;
            BLT:     r.taken = lt_s;
            BGE:     r.taken = !lt_s;
            BLTU:    r.taken = lt_u;
            BGEU:    r.taken = !lt_u;
            default: r.taken = 1'b0;
        endcase
        // Immediate counts halfwords
        offset       = int'($signed(op.imm)) * 2;
        r.pc         = op.pc;
        r.target     = op.pc + 32'(offset);
        r.mispredict = (r.taken != op.pred_taken) || (r.taken && op.pred_target != r.target);
        return r;
    endfunction

    function automatic logic [`BR_XLEN-1:0] model_redirect(input branch_op_t op);
        branch_res_t r;
        r = model_res(op);
        return r.taken ? r.target : op.pc + 32'd4;
    endfunction

    // Fresh op with random pc and immediate, no prediction yet
    function automatic branch_op_t make_op(input logic [2:0] code,
                                           input logic [31:0] a, input logic [31:0] b);
        branch_op_t op;
        op     = '0;
        op.ctl = bu_ctl_e'(code);
        op.rs1 = a;
        op.rs2 = b;
        op.pc  = lfsr_bits(30) << 2;
        op.imm = `BR_B_IMM'(lfsr_bits(`BR_B_IMM));
        return op;
    endfunction

    function automatic branch_op_t predict_right(input branch_op_t op);
        branch_res_t r;
        r              = model_res(op);
        op.pred_taken  = r.taken;
        op.pred_target = r.target;
        return op;
    endfunction

    task automatic check_res(input string name, input branch_res_t exp, input branch_res_t act);
        if (act !== exp) begin
            error_count++;
            $display("ERROR %s: expected pc=%h target=%h taken=%b mis=%b, %s",
                     name, exp.pc, exp.target, exp.taken, exp.mispredict,
                     $sformatf("actual pc=%h target=%h taken=%b mis=%b",
                               act.pc, act.target, act.taken, act.mispredict));
        end
    endtask

    task automatic check_pc(input string name, input logic [`BR_XLEN-1:0] exp,
                            input logic [`BR_XLEN-1:0] act);
        if (act !== exp) begin
            error_count++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            error_count++;
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Clears the streams on a rising edge, returns on a falling edge
    task automatic start_test(input string name);
        @(posedge clk_i);
        test_name      = name;
        test_err_start = error_count;
        stall_count    = 0;
        got_res.delete();
        exp_res.delete();
        got_redir.delete();
        exp_redir.delete();
        ready_in_flush.delete();
        @(negedge clk_i);
    endtask

    task automatic end_test();
        int errs;
        errs = error_count - test_err_start;
        if (errs != 0) begin
            failed_tests++;
        end
        $display("test %s %s, %0d errors", test_name, (errs == 0) ? "passed" : "FAILED", errs);
    endtask

    // Called on a falling edge, holds the op until the queue takes it
    task automatic issue_op(input branch_op_t op, input logic expect_it);
        int          waited;
        branch_res_t r;
        waited        = 0;
        r             = model_res(op);
        issue_valid_i = 1'b1;
        issue_op_i    = op;
        if (expect_it) begin
            exp_res.push_back(r);
            if (r.mispredict) begin
                exp_redir.push_back(model_redirect(op));
            end
        end
        while (!issue_ready_o && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!issue_ready_o) begin
            error_count++;
            $display("%s: the queue never accepted an op", test_name);
        end else begin
            @(negedge clk_i);
        end
        stall_count  += waited;
        issue_valid_i = 1'b0;
    endtask

    task automatic wait_until(input int n_res, input int n_redir);
        int cyc;
        cyc = 0;
        while ((got_res.size() < n_res || got_redir.size() < n_redir) && cyc < WAIT_LIMIT) begin
            @(posedge clk_i);
            cyc++;
        end
        if (got_res.size() < n_res || got_redir.size() < n_redir) begin
            error_count++;
            $display("%s: timed out waiting for results or redirects", test_name);
        end
    endtask

    // Extra cycles expose results that should never have appeared
    task automatic settle_and_compare();
        repeat (SETTLE_CYC) @(posedge clk_i);
        @(negedge clk_i);
        if (got_res.size() != exp_res.size() || got_redir.size() != exp_redir.size()) begin
            error_count++;
            $display("%s: saw %0d results and %0d redirects, wanted %0d and %0d", test_name,
                     got_res.size(), got_redir.size(), exp_res.size(), exp_redir.size());
        end
        for (int i = 0; i < exp_res.size() && i < got_res.size(); i++) begin
            check_res($sformatf("%s result %0d", test_name, i), exp_res[i], got_res[i]);
        end
        for (int i = 0; i < exp_redir.size() && i < got_redir.size(); i++) begin
            check_pc($sformatf("%s redirect %0d", test_name, i), exp_redir[i], got_redir[i]);
        end
    endtask

    task automatic test_reset();
        start_test("reset");
        check_bit("reset res_valid_o", 1'b0, res_valid_o);
        check_bit("reset redirect_valid_o", 1'b0, redirect_valid_o);
        check_bit("reset issue_ready_o", 1'b1, issue_ready_o);
        end_test();
    endtask

    // All eight codes against equal, mixed-sign and unsigned-large pairs
    task automatic test_conditions();
        logic [31:0] a;
        logic [31:0] b;
        start_test("conditions");
        for (int code = 0; code < 8; code++) begin
            for (int p = 0; p < 3; p++) begin
                if (p == 0) begin
                    a = lfsr_bits(32);
                    b = a;
                end else if (p == 1) begin
                    a = lfsr_bits(31);
                    b = lfsr_bits(31) | 32'h8000_0000;
                end else begin
                    a = 32'hffff_ff00 | lfsr_bits(8);
                    b = lfsr_bits(16);
                end
                issue_op(predict_right(make_op(3'(code), a, b)), 1'b1);
            end
        end
        wait_until(exp_res.size(), 0);
        settle_and_compare();
        end_test();
    endtask

    // Each case alone, since a redirect flushes what follows
    task automatic test_prediction();
        logic [31:0] a;
        branch_op_t  op;
        start_test("prediction");
        a = lfsr_bits(32);
        for (int c = 0; c < 5; c++) begin
            case (c)
                0: op = predict_right(make_op(BEQ, a, a));
                1: begin
                    op = make_op(BEQ, a, a);
                    op.pred_taken = 1'b0;
                end
                2: begin
                    // Falls through to pc plus 4
                    op = make_op(BNE, a, a);
                    op.pred_taken  = 1'b1;
                    op.pred_target = lfsr_bits(32);
                end
                3: begin
                    op = predict_right(make_op(BGE, a, a));
                    op.pred_target = op.pred_target + 32'd8;
                end
                default: begin
                    // Stale target is harmless when not taken
                    op = predict_right(make_op(BNE, a, a));
                    op.pred_target = lfsr_bits(32);
                end
            endcase
            issue_op(op, 1'b1);
            wait_until(exp_res.size(), exp_redir.size());
            @(negedge clk_i);
        end
        settle_and_compare();
        end_test();
    endtask

    task automatic test_flush();
        logic [31:0] a;
        branch_op_t  op;
        start_test("flush");
        a  = lfsr_bits(32);
        op = make_op(BEQ, a, a);
        op.pred_taken = 1'b0;
        issue_op(op, 1'b1);
        // Younger wrong-path ops right behind it
        repeat (2) begin
            issue_op(predict_right(make_op(BNE, lfsr_bits(32), lfsr_bits(32))), 1'b0);
        end
        wait_until(1, 1);
        @(negedge clk_i);
        repeat (2) begin
            issue_op(predict_right(make_op(BLT, lfsr_bits(32), lfsr_bits(32))), 1'b1);
        end
        wait_until(3, 1);
        settle_and_compare();
        if (ready_in_flush.size() > 0) begin
            check_bit("flush issue_ready_o", 1'b0, ready_in_flush[0]);
        end
        end_test();
    endtask

    // Queue drains one op per cycle, so issue never stalls
    task automatic test_burst();
        int n;
        start_test("burst");
        n = `BR_QUEUE_DEPTH + 3;
        for (int i = 0; i < n; i++) begin
            issue_op(predict_right(make_op(3'(lfsr_bits(3)), lfsr_bits(32), lfsr_bits(32))), 1'b1);
        end
        wait_until(n, 0);
        settle_and_compare();
        if (stall_count != 0) begin
            error_count++;
            $display("%s: issue_ready_o dropped %0d times while the queue was draining",
                     test_name, stall_count);
        end
        end_test();
    endtask

    initial begin
        rst_n_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_op_i    = '0;
        repeat (RESET_CYC) @(negedge clk_i);
        rst_n_i = 1'b1;
        test_reset();
        test_conditions();
        test_prediction();
        test_flush();
        test_burst();
        $display("Summary: %0d tests, %0d failed, %0d errors", N_TESTS, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- branch_exec.f
+incdir+design
design/branch_pkg.sv
design/branch_issue_queue.sv
design/branch_unit_cu.sv
design/branch_unit.sv
design/branch_redirect.sv
design/branch_exec.sv
bench/tb_branch_exec.sv

//--- Bender.yml
package:
  name: branch_exec

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/branch_pkg.sv
      - design/branch_issue_queue.sv
      - design/branch_unit_cu.sv
      - design/branch_unit.sv
      - design/branch_redirect.sv
      - design/branch_exec.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/tb_branch_exec.sv
